/* hw/fsync_pkg.sv */
// Barrier network package with tree sizes, field widths and register map
package fsync_pkg;

  // Tree shape
  localparam int unsigned N_TILES   = 8;
  localparam int unsigned FSYNC_LVL = 3;            // Node levels from leaves to top
  localparam int unsigned N_NODES   = N_TILES - 1;  // 4 + 2 + 1 two-input nodes

  // Level field, values 1 to 3 are legal
  localparam int unsigned LVL_W = 2;

  // Timer and event counters
  localparam int unsigned CNT_W = 32;

  // Wishbone slave widths, byte addressed
  localparam int unsigned WB_ADDR_W = 4;
  localparam int unsigned WB_DATA_W = 32;

  // Register byte offsets
  localparam logic [WB_ADDR_W-1:0] REG_TIMER    = 4'h0;
  localparam logic [WB_ADDR_W-1:0] REG_BARRIERS = 4'h4;
  localparam logic [WB_ADDR_W-1:0] REG_ERRORS   = 4'h8;
  localparam logic [WB_ADDR_W-1:0] REG_STATUS   = 4'hC;  // Bit 0 sticky error flag

endpackage

/* hw/fsync_node.sv */
// Two-child barrier node that collects arrivals, forwards upward or releases its children
module fsync_node (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        req_a_i,
  input  logic                        req_b_i,
  input  logic [fsync_pkg::LVL_W-1:0] lvl_a_i,
  input  logic [fsync_pkg::LVL_W-1:0] lvl_b_i,
  output logic                        ack_a_o,
  output logic                        ack_b_o,
  output logic                        up_req_o,
  output logic [fsync_pkg::LVL_W-1:0] up_lvl_o,
  input  logic                        up_ack_i,
  output logic                        done_o,
  output logic                        error_o
);
  import fsync_pkg::*;

  logic             arr_a_q;   // Child A has arrived
  logic             arr_b_q;
  logic [LVL_W-1:0] lvl_a_q;
  logic [LVL_W-1:0] lvl_b_q;
  logic             wait_q;    // Forwarded, parent ack pending
  logic             ack_q;
  logic             up_req_q;
  logic [LVL_W-1:0] up_lvl_q;
  logic             done_q;
  logic             error_q;

  logic             have_a;
  logic             have_b;
  logic [LVL_W-1:0] cur_lvl_a;
  logic [LVL_W-1:0] cur_lvl_b;
  logic             fire;

  // Arrivals seen so far, including the ones sampled at this edge
  always_comb begin
    have_a    = arr_a_q | req_a_i;
    have_b    = arr_b_q | req_b_i;
    cur_lvl_a = req_a_i ? lvl_a_i : lvl_a_q;
    cur_lvl_b = req_b_i ? lvl_b_i : lvl_b_q;
    fire      = have_a & have_b;  // Last of the two arrivals
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      arr_a_q  <= 1'b0;
      arr_b_q  <= 1'b0;
      wait_q   <= 1'b0;
      ack_q    <= 1'b0;
      up_req_q <= 1'b0;
      done_q   <= 1'b0;
      error_q  <= 1'b0;
    end else begin
      // Pulses by default
      ack_q    <= 1'b0;
      up_req_q <= 1'b0;
      done_q   <= 1'b0;
      error_q  <= 1'b0;

      if (fire) begin
        arr_a_q <= 1'b0;
        arr_b_q <= 1'b0;
        if (cur_lvl_a != cur_lvl_b) begin
          // Children disagree on the barrier, release both and flag it
          ack_q   <= 1'b1;
          error_q <= 1'b1;
        end else if (cur_lvl_a == LVL_W'(1)) begin
          ack_q  <= 1'b1;  // Barrier completes here
          done_q <= 1'b1;
        end else begin
          up_req_q <= 1'b1;
          wait_q   <= 1'b1;
        end
      end else begin
        arr_a_q <= have_a;
        arr_b_q <= have_b;
      end

      // Release coming back down from the parent
      if (wait_q && up_ack_i) begin
        ack_q  <= 1'b1;
        wait_q <= 1'b0;
      end
    end
  end

  // Level payload
  always_ff @(posedge clk) begin
    if (req_a_i) lvl_a_q <= lvl_a_i;
    if (req_b_i) lvl_b_q <= lvl_b_i;
    if (fire) up_lvl_q <= cur_lvl_a - LVL_W'(1);  // One level less per hop
  end

  assign ack_a_o  = ack_q;
  assign ack_b_o  = ack_q;
  assign up_req_o = up_req_q;
  assign up_lvl_o = up_lvl_q;
  assign done_o   = done_q;
  assign error_o  = error_q;

  // A child may only request again after its release
  a_no_rereq_a : assert property (@(posedge clk) disable iff (!rst_n_i)
    req_a_i |-> !(arr_a_q || wait_q))
    else $error("child A requested while pending");
  a_no_rereq_b : assert property (@(posedge clk) disable iff (!rst_n_i)
    req_b_i |-> !(arr_b_q || wait_q))
    else $error("child B requested while pending");

  // Level 0 names no barrier
  a_lvl_legal : assert property (@(posedge clk) disable iff (!rst_n_i)
    (req_a_i |-> lvl_a_i != '0) and (req_b_i |-> lvl_b_i != '0))
    else $error("level 0 request");

endmodule

/* hw/fsync_tree.sv */
// Synchronization tree of two-input barrier nodes over the tile mesh
module fsync_tree (
  input  logic                                          clk,
  input  logic                                          rst_n_i,
  input  logic [fsync_pkg::N_TILES-1:0]                 sync_req_i,
  input  logic [fsync_pkg::N_TILES*fsync_pkg::LVL_W-1:0] sync_lvl_i,
  output logic [fsync_pkg::N_TILES-1:0]                 sync_ack_o,
  output logic                                          top_req_o,
  output logic [fsync_pkg::LVL_W-1:0]                   top_lvl_o,
  input  logic                                          top_ack_i,
  output logic [fsync_pkg::N_NODES-1:0]                 done_o,
  output logic [fsync_pkg::N_NODES-1:0]                 error_o
);
  import fsync_pkg::*;

  // Up port of every node, leaves first, top node last
  logic [N_NODES-1:0] up_req;
  logic [LVL_W-1:0]   up_lvl [N_NODES];
  logic [N_NODES-1:0] up_ack;

  // Level one pairs neighbouring tiles
  for (genvar i = 0; i < N_TILES / 2; i++) begin : gen_leaf
    fsync_node i_node (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .req_a_i  (sync_req_i[2*i]),
      .req_b_i  (sync_req_i[2*i+1]),
      .lvl_a_i  (sync_lvl_i[(2*i)*LVL_W +: LVL_W]),
      .lvl_b_i  (sync_lvl_i[(2*i+1)*LVL_W +: LVL_W]),
      .ack_a_o  (sync_ack_o[2*i]),
      .ack_b_o  (sync_ack_o[2*i+1]),
      .up_req_o (up_req[i]),
      .up_lvl_o (up_lvl[i]),
      .up_ack_i (up_ack[i]),
      .done_o   (done_o[i]),
      .error_o  (error_o[i])
    );
  end

  // Higher levels join the up ports of two nodes below
  for (genvar l = 1; l < FSYNC_LVL; l++) begin : gen_level
    for (genvar j = 0; j < (N_TILES >> (l + 1)); j++) begin : gen_node
      localparam int PAR = N_TILES - (N_TILES >> l) + j;            // This node
      localparam int CH  = N_TILES - (N_TILES >> (l - 1)) + 2 * j;  // Its first child

      fsync_node i_node (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req_a_i  (up_req[CH]),
        .req_b_i  (up_req[CH+1]),
        .lvl_a_i  (up_lvl[CH]),
        .lvl_b_i  (up_lvl[CH+1]),
        .ack_a_o  (up_ack[CH]),
        .ack_b_o  (up_ack[CH+1]),
        .up_req_o (up_req[PAR]),
        .up_lvl_o (up_lvl[PAR]),
        .up_ack_i (up_ack[PAR]),
        .done_o   (done_o[PAR]),
        .error_o  (error_o[PAR])
      );
    end
  end

  // Top node talks to the monitor
  assign top_req_o           = up_req[N_NODES-1];
  assign top_lvl_o           = up_lvl[N_NODES-1];
  assign up_ack[N_NODES-1]   = top_ack_i;

endmodule

/* hw/fsync_monitor.sv */
// Root monitor that catches overflow and serves timer, counters and status over Wishbone
module fsync_monitor (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  logic                            top_req_i,
  input  logic [fsync_pkg::LVL_W-1:0]     top_lvl_i,
  output logic                            top_ack_o,
  input  logic [fsync_pkg::N_NODES-1:0]   node_done_i,
  input  logic [fsync_pkg::N_NODES-1:0]   node_error_i,
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [fsync_pkg::WB_ADDR_W-1:0] wb_adr_i,
  input  logic [fsync_pkg::WB_DATA_W-1:0] wb_dat_i,
  output logic [fsync_pkg::WB_DATA_W-1:0] wb_dat_o,
  output logic                            wb_ack_o,
  output logic                            error_o
);
  import fsync_pkg::*;

  logic [CNT_W-1:0]     timer_q;
  logic [CNT_W-1:0]     barriers_q;
  logic [CNT_W-1:0]     errors_q;
  logic                 err_flag_q;
  logic [LVL_W-1:0]     ovf_lvl_q;   // Level of the last overflow
  logic                 top_ack_q;
  logic                 wb_ack_q;
  logic [WB_DATA_W-1:0] wb_dat_q;

  logic                 wb_req;
  logic                 clr;
  logic [CNT_W-1:0]     n_done;
  logic [CNT_W-1:0]     n_err;
  logic [WB_DATA_W-1:0] rd_data;

  always_comb begin
    wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_q;  // New access, not the one being acked
    clr    = wb_req & wb_we_i & (wb_adr_i == REG_STATUS);
    // Several nodes may pulse at once
    n_done = CNT_W'($countones(node_done_i));
    n_err  = CNT_W'($countones(node_error_i)) + CNT_W'(top_req_i);

    case (wb_adr_i)
      REG_TIMER:    rd_data = WB_DATA_W'(timer_q);
      REG_BARRIERS: rd_data = WB_DATA_W'(barriers_q);
      REG_ERRORS:   rd_data = WB_DATA_W'(errors_q);
      REG_STATUS:   rd_data = WB_DATA_W'({ovf_lvl_q, err_flag_q});
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      timer_q    <= '0;
      barriers_q <= '0;
      errors_q   <= '0;
      err_flag_q <= 1'b0;
      ovf_lvl_q  <= '0;
      top_ack_q  <= 1'b0;
      wb_ack_q   <= 1'b0;
    end else begin
      timer_q   <= timer_q + CNT_W'(1);  // Free running, never cleared
      top_ack_q <= top_req_i;            // Release whatever climbed past the top
      wb_ack_q  <= wb_req;

      if (clr) begin
        barriers_q <= '0;
        errors_q   <= '0;
        err_flag_q <= 1'b0;
        ovf_lvl_q  <= '0;
      end else begin
        barriers_q <= barriers_q + n_done;
        errors_q   <= errors_q + n_err;
        if (n_err != '0) err_flag_q <= 1'b1;  // Sticky
        if (top_req_i) ovf_lvl_q <= top_lvl_i;
      end
    end
  end

  // Read data travels with the ack
  always_ff @(posedge clk) begin
    if (wb_req) wb_dat_q <= wb_we_i ? '0 : rd_data;
  end

  assign top_ack_o = top_ack_q;
  assign wb_dat_o  = wb_dat_q;
  assign wb_ack_o  = wb_ack_q;
  assign error_o   = err_flag_q;

  // Master keeps its access steady until the ack
  a_master_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_cyc_i && wb_stb_i && !wb_ack_o |=> wb_cyc_i && wb_stb_i && $stable(wb_we_i)
      && $stable(wb_adr_i) && $stable(wb_dat_i))
    else $error("Wishbone master changed its access before the ack");

endmodule

/* hw/fsync_top.sv */
// Barrier network top joining the synchronization tree and its root monitor
module fsync_top (
  input  logic                                           clk,
  input  logic                                           rst_n_i,
  input  logic [fsync_pkg::N_TILES-1:0]                  sync_req_i,
  input  logic [fsync_pkg::N_TILES*fsync_pkg::LVL_W-1:0] sync_lvl_i,
  output logic [fsync_pkg::N_TILES-1:0]                  sync_ack_o,
  input  logic                                           wb_cyc_i,
  input  logic                                           wb_stb_i,
  input  logic                                           wb_we_i,
  input  logic [fsync_pkg::WB_ADDR_W-1:0]                wb_adr_i,
  input  logic [fsync_pkg::WB_DATA_W-1:0]                wb_dat_i,
  output logic [fsync_pkg::WB_DATA_W-1:0]                wb_dat_o,
  output logic                                           wb_ack_o,
  output logic                                           error_o
);
  import fsync_pkg::*;

  logic               top_req;
  logic [LVL_W-1:0]   top_lvl;
  logic               top_ack;
  logic [N_NODES-1:0] node_done;
  logic [N_NODES-1:0] node_error;

  fsync_tree i_tree (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .sync_req_i (sync_req_i),
    .sync_lvl_i (sync_lvl_i),
    .sync_ack_o (sync_ack_o),
    .top_req_o  (top_req),
    .top_lvl_o  (top_lvl),
    .top_ack_i  (top_ack),
    .done_o     (node_done),
    .error_o    (node_error)
  );

  fsync_monitor i_monitor (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .top_req_i    (top_req),
    .top_lvl_i    (top_lvl),
    .top_ack_o    (top_ack),
    .node_done_i  (node_done),
    .node_error_i (node_error),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .error_o      (error_o)
  );

endmodule

/* bench/fsync_tb_ref.svh */
// Reference model of barrier groups, release timing, event counters and the random source
`ifndef FSYNC_TB_REF_SVH
`define FSYNC_TB_REF_SVH

// Next state of the linear congruential generator
function automatic int unsigned lcg_next(input int unsigned s);
  return s * 32'd1103515245 + 32'd12345;
endfunction

// Tiles of the aligned block of 2^lvl tiles starting at base
function automatic logic [N_TILES-1:0] group_mask(input int base, input int lvl);
  logic [N_TILES-1:0] m;
  int                 i;
  m = '0;
  for (i = 0; i < N_TILES; i++) begin
    if (i >= base && i < base + (1 << lvl)) m[i] = 1'b1;
  end
  return m;
endfunction

// Edge that samples the acks of a group whose last request is sampled at last_edge
function automatic int release_edge(input int last_edge, input int lvl, input bit bad);
  if (bad) return last_edge + 1;   // Pair node releases at once on a mismatch
  return last_edge + 2 * lvl - 1;  // lvl-1 hops up, decision, lvl-1 hops down
endfunction

// Completed barriers after one more group
function automatic int barriers_after(input int cur, input bit bad);
  return bad ? cur : cur + 1;
endfunction

// Errors after one more group, a mismatch counts once
function automatic int errors_after(input int cur, input bit bad);
  return bad ? cur + 1 : cur;
endfunction

`endif

/* bench/fsync_tb.sv */
// Testbench for the barrier network with tile traffic, Wishbone register checks and a timeout
module fsync_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fsync_pkg::*;

  localparam int          CLK_PERIOD = 40;
  localparam int unsigned LCG_SEED   = 10;
  localparam int          N_PLANNED  = 27;  // Barriers over all tests
  localparam int          CYC_LIMIT  = 50 * N_PLANNED + 200;

  logic                     clk;
  logic                     rst_n_i;
  logic [N_TILES-1:0]       sync_req_i;
  logic [N_TILES*LVL_W-1:0] sync_lvl_i;
  logic [N_TILES-1:0]       sync_ack_o;
  logic                     wb_cyc_i;
  logic                     wb_stb_i;
  logic                     wb_we_i;
  logic [WB_ADDR_W-1:0]     wb_adr_i;
  logic [WB_DATA_W-1:0]     wb_dat_i;
  logic [WB_DATA_W-1:0]     wb_dat_o;
  logic                     wb_ack_o;
  logic                     error_o;

  int unsigned        lcg_state = LCG_SEED;
  int                 cycle_cnt = 0;  // Rising edges so far
  int                 exp_bars  = 0;
  int                 exp_errs  = 0;
  logic [N_TILES-1:0] exp_ack [CYC_LIMIT+8];  // Indexed by the edge that samples the ack
  int                 g_base [$];             // Groups of the next round
  int                 g_lvl [$];
  bit                 g_bad [$];

  `include "fsync_tb_ref.svh"

  fsync_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYC_LIMIT) fail_run("Timeout, the run did not end within the cycle limit");
  end

  // Mid-cycle ack is the one the next edge samples
  always @(negedge clk) begin
    if (rst_n_i) check_ack(sync_ack_o, exp_ack[cycle_cnt+1]);
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at cycle %0d", cycle_cnt);
  endtask

  task automatic check_ack(input logic [N_TILES-1:0] got, input logic [N_TILES-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch sync_ack_o at cycle %0d: got 0x%h, expected 0x%h", cycle_cnt, got, exp);
      fail_run("Tile release pattern is wrong");
    end
  endtask

  task automatic check_word(input string name, input logic [WB_DATA_W-1:0] got,
                            input logic [WB_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_run("Register value is wrong");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_run("Error flag is wrong");
    end
  endtask

  task automatic rand_below(input int unsigned n, output int v);
    lcg_state = lcg_next(lcg_state);
    v = int'((lcg_state >> 16) % n);  // Upper bits are the better ones
  endtask

  // Inputs change a little after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic add_group(input int base, input int lvl, input bit bad);
    g_base.push_back(base);
    g_lvl.push_back(lvl);
    g_bad.push_back(bad);
  endtask

  // Random arrivals for every queued group, predicted releases, then drain
  task automatic run_round(input int max_gap);
    int                 off [N_TILES];
    logic [N_TILES-1:0] mask;
    logic [N_TILES-1:0] req;
    int                 start;
    int                 last;
    int                 span;
    int                 done_edge;
    int                 r;
    int                 g;
    int                 i;
    int                 t;
    start     = cycle_cnt + 1;
    span      = 0;
    done_edge = 0;
    for (i = 0; i < N_TILES; i++) off[i] = -1;
    for (g = 0; g < g_base.size(); g++) begin
      mask = group_mask(g_base[g], g_lvl[g]);
      last = 0;
      for (i = 0; i < N_TILES; i++) begin
        if (mask[i]) begin
          rand_below(max_gap, r);
          off[i] = r;
          sync_lvl_i[i*LVL_W +: LVL_W] = LVL_W'(g_lvl[g]);
          if (r > last) last = r;
          if (r > span) span = r;
        end
      end
      if (g_bad[g]) begin
        rand_below(2, r);
        sync_lvl_i[(g_base[g]+1)*LVL_W +: LVL_W] = LVL_W'(2 + r);  // Partner wants more
      end
      r = release_edge(start + last, g_lvl[g], g_bad[g]);
      exp_ack[r] = exp_ack[r] | mask;
      if (r > done_edge) done_edge = r;
      exp_bars = barriers_after(exp_bars, g_bad[g]);
      exp_errs = errors_after(exp_errs, g_bad[g]);
    end
    for (t = 0; t <= span; t++) begin
      for (i = 0; i < N_TILES; i++) req[i] = (off[i] == t);
      sync_req_i = req;
      step();
    end
    sync_req_i = '0;
    while (cycle_cnt < done_edge + 2) step();
    g_base.delete();
    g_lvl.delete();
    g_bad.delete();
  endtask

  // One classic cycle; stamp is the edge that sampled it
  task automatic bus_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                            input logic [WB_DATA_W-1:0] wdat,
                            output logic [WB_DATA_W-1:0] rdat, output int stamp);
    int waited;
    waited   = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 4) fail_run("Wishbone ack did not arrive");
    end while (wb_ack_o !== 1'b1);
    rdat  = wb_dat_o;
    stamp = cycle_cnt;
    step();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  initial begin
    logic [WB_DATA_W-1:0] rd;
    logic [WB_DATA_W-1:0] t1;
    int                   s1;
    int                   s2;
    int                   k;
    int                   r;
    int                   lvl;
    for (k = 0; k < CYC_LIMIT + 8; k++) exp_ack[k] = '0;
    rst_n_i    = 1'b0;
    sync_req_i = '0;
    sync_lvl_i = '0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    repeat (4) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    check_flag("error_o", error_o, 1'b0);

    for (k = 0; k < 6; k++) begin  // Single pairs
      rand_below(N_TILES / 2, r);
      add_group(2 * r, 1, 1'b0);
      run_round(4);
    end
    for (k = 0; k < 7; k++) begin  // Quads, then the whole mesh
      lvl = (k < 4) ? 2 : 3;
      rand_below(N_TILES >> lvl, r);
      add_group(r << lvl, lvl, 1'b0);
      run_round(8);
    end

    // Separate groups side by side
    add_group(0, 2, 1'b0);
    add_group(4, 1, 1'b0);
    add_group(6, 1, 1'b0);
    run_round(6);
    add_group(0, 1, 1'b0);
    add_group(2, 1, 1'b0);
    add_group(4, 2, 1'b0);
    run_round(6);
    add_group(0, 2, 1'b0);
    add_group(4, 2, 1'b0);
    run_round(6);
    for (k = 0; k < N_TILES / 2; k++) add_group(2 * k, 1, 1'b0);
    run_round(6);
    bus_access(1'b0, REG_BARRIERS, '0, rd, s1);
    check_word("REG_BARRIERS", rd, WB_DATA_W'(exp_bars));
    bus_access(1'b0, REG_ERRORS, '0, rd, s1);
    check_word("REG_ERRORS", rd, WB_DATA_W'(exp_errs));

    for (k = 0; k < 2; k++) begin  // Pair disagrees on the level
      rand_below(N_TILES / 2, r);
      add_group(2 * r, 1, 1'b1);
      run_round(4);
    end
    bus_access(1'b0, REG_ERRORS, '0, rd, s1);
    check_word("REG_ERRORS", rd, WB_DATA_W'(exp_errs));
    check_flag("error_o", error_o, 1'b1);
    bus_access(1'b0, REG_STATUS, '0, rd, s1);
    check_flag("REG_STATUS[0]", rd[0], 1'b1);

    bus_access(1'b1, REG_STATUS, 32'h1, rd, s1);  // Clear
    bus_access(1'b0, REG_BARRIERS, '0, rd, s1);
    check_word("REG_BARRIERS", rd, '0);
    bus_access(1'b0, REG_ERRORS, '0, rd, s1);
    check_word("REG_ERRORS", rd, '0);
    check_flag("error_o", error_o, 1'b0);
    bus_access(1'b0, REG_STATUS, '0, rd, s1);
    check_flag("REG_STATUS[0]", rd[0], 1'b0);
    bus_access(1'b0, REG_TIMER, '0, t1, s1);
    rand_below(20, r);
    repeat (r) step();
    bus_access(1'b0, REG_TIMER, '0, rd, s2);
    check_word("REG_TIMER delta", rd - t1, WB_DATA_W'(s2 - s1));

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* fsync_top.f */
+incdir+bench
hw/fsync_pkg.sv
hw/fsync_node.sv
hw/fsync_tree.sv
hw/fsync_monitor.sv
hw/fsync_top.sv
bench/fsync_tb.sv

/* Makefile */
# Verilator build and run of the barrier network testbench
VERILATOR ?= verilator
TOP       ?= fsync_tb
FLIST     ?= fsync_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: sim clean

# Pass or fail comes from the log, not from the simulator exit code
sim:
	$(VERILATOR) --binary --timing --assert -j 0 --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -f $(FLIST) $(VFLAGS)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
